/* rtl/tenyr_pkg.sv */
package tenyr_pkg;

    // Word-addressed address map
    localparam logic [31:0] RAM_BASE   = 32'h0000_1000;
    localparam int unsigned RAM_ABITS  = 8;
    localparam logic [31:0] RAM_MASK   = ~((32'd1 << RAM_ABITS) - 32'd1);
    localparam logic [31:0] SEG7_BASE  = 32'h0000_0100;
    localparam logic [31:0] SEG7_MASK  = 32'hffff_fffe;   // 2 words
    localparam logic [31:0] GPIO_BASE  = 32'h0000_0200;
    localparam logic [31:0] GPIO_MASK  = 32'hffff_fffc;   // 4 words

    localparam int unsigned GPIO_COUNT = 24;
    localparam int unsigned FIFO_DEPTH = 4;
    localparam int unsigned FIFO_PW    = $clog2(FIFO_DEPTH);
    localparam int unsigned FIFO_CW    = $clog2(FIFO_DEPTH + 1);
    localparam int unsigned SCAN_DIV   = 4;                // Short for simulation
    localparam int unsigned SCAN_W     = $clog2(SCAN_DIV);

    // Slave order also sets decode priority
    localparam int unsigned NUM_SLAVES = 4;
    localparam int unsigned SLV_W      = $clog2(NUM_SLAVES);
    localparam int unsigned SLV_GPIO   = 0;
    localparam int unsigned SLV_SEG7   = 1;
    localparam int unsigned SLV_RAM    = 2;
    localparam int unsigned SLV_DEF    = 3;

    // Default slave matches everything
    localparam logic [NUM_SLAVES-1:0][31:0] MATCH_BASE = {
        32'h0, RAM_BASE, SEG7_BASE, GPIO_BASE};
    localparam logic [NUM_SLAVES-1:0][31:0] MATCH_MASK = {
        32'h0, RAM_MASK, SEG7_MASK, GPIO_MASK};

    // Bus master sequencer states
    localparam logic [1:0] MST_IDLE = 2'd0;
    localparam logic [1:0] MST_BUS  = 2'd1;
    localparam logic [1:0] MST_RESP = 2'd2;

    typedef union packed {
        struct packed {
            logic [31-RAM_ABITS:0] tag;
            logic [RAM_ABITS-1:0]  idx;   // RAM word index
        } mem;
        struct packed {
            logic [29:0] page;
            logic [1:0]  rnum;            // Device register number
        } io;
    } wb_adr_u;

    typedef struct packed {
        logic        we;
        logic [3:0]  sel;
        wb_adr_u     adr;
        logic [31:0] dat;
    } host_cmd_t;

    typedef struct packed {
        logic [31:0] dat;
    } host_rsp_t;

    typedef struct packed {
        wb_adr_u     adr;
        logic [31:0] dat;
        logic        we;
        logic [3:0]  sel;
        logic        stb;
        logic        cyc;
    } wb_req_t;

    typedef struct packed {
        logic [31:0] dat;
        logic        ack;
    } wb_rsp_t;

endpackage

/* rtl/host_cmd_fifo.sv */
module host_cmd_fifo import tenyr_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  logic      push_valid_i,
    output logic      push_ready_o,
    input  host_cmd_t push_cmd_i,
    output logic      pop_valid_o,
    input  logic      pop_i,
    output host_cmd_t pop_cmd_o
);

    host_cmd_t          mem_q [FIFO_DEPTH];
    logic [FIFO_PW-1:0] wr_ptr_q;
    logic [FIFO_PW-1:0] rd_ptr_q;
    logic [FIFO_CW-1:0] count_q;
    logic               push;
    logic               pop;

    assign push_ready_o = (count_q != FIFO_CW'(FIFO_DEPTH));   // Low only when full
    assign pop_valid_o  = (count_q != '0);
    assign push         = push_valid_i & push_ready_o;
    assign pop          = pop_i & pop_valid_o;
    assign pop_cmd_o    = mem_q[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (push) begin
            mem_q[wr_ptr_q] <= push_cmd_i;
        end
    end

    // Pointers wrap at the power-of-two depth
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;            // Both or neither
            endcase
        end
    end

endmodule

/* rtl/wb_host_master.sv */
module wb_host_master import tenyr_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  logic      cmd_valid_i,
    output logic      cmd_pop_o,
    input  host_cmd_t cmd_i,
    output wb_req_t   wb_req_o,
    input  wb_rsp_t   wb_rsp_i,
    output logic      rsp_valid_o,
    output host_rsp_t rsp_o
);

    logic [1:0]  state_q;
    host_cmd_t   cmd_q;
    logic [31:0] rdata_q;
    logic        bus_q;

    assign bus_q     = (state_q == MST_BUS);
    assign cmd_pop_o = (state_q == MST_IDLE) & cmd_valid_i;   // Take one command at a time

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= MST_IDLE;
        end else begin
            case (state_q)
                MST_IDLE: if (cmd_valid_i) state_q <= MST_BUS;
                MST_BUS:  if (wb_rsp_i.ack) state_q <= MST_RESP;
                MST_RESP: state_q <= MST_IDLE;
                default:  state_q <= MST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_pop_o) begin
            cmd_q <= cmd_i;
        end
        if (bus_q && wb_rsp_i.ack) begin
            rdata_q <= wb_rsp_i.dat;               // Write cycles capture it too
        end
    end

    // Request held stable from the latched command until ack
    always_comb begin
        wb_req_o.adr = cmd_q.adr;
        wb_req_o.dat = cmd_q.dat;
        wb_req_o.we  = cmd_q.we;
        wb_req_o.sel = cmd_q.sel;
        wb_req_o.stb = bus_q;
        wb_req_o.cyc = bus_q;
    end

    assign rsp_valid_o = (state_q == MST_RESP);   // One cycle after ack
    assign rsp_o.dat   = rdata_q;

endmodule

/* rtl/wb_mux.sv */
module wb_mux import tenyr_pkg::*; (
    input  logic    clk,
    input  logic    reset_i,
    input  wb_req_t m_req_i,
    output wb_rsp_t m_rsp_o,
    output wb_req_t s_req_o [NUM_SLAVES],
    input  wb_rsp_t s_rsp_i [NUM_SLAVES]
);

    logic [SLV_W-1:0] sel_dec;
    logic [SLV_W-1:0] sel_q;
    logic [SLV_W-1:0] sel;
    logic             hold_q;
    wb_rsp_t          rsp_all [NUM_SLAVES];

    // Scan from the back so the first match in slave order wins
    always_comb begin
        sel_dec = SLV_W'(SLV_DEF);
        for (int k = NUM_SLAVES - 1; k >= 0; k--) begin
            if ((m_req_i.adr & MATCH_MASK[k]) == MATCH_BASE[k]) begin
                sel_dec = SLV_W'(k);
            end
        end
    end

    // Routing stays locked from the first strobe cycle until the ack
    assign sel = hold_q ? sel_q : sel_dec;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            hold_q <= 1'b0;
            sel_q  <= '0;
        end else begin
            hold_q <= m_req_i.cyc & ~m_rsp_o.ack;
            sel_q  <= sel;
        end
    end

    always_comb begin
        for (int k = 0; k < NUM_SLAVES; k++) begin
            s_req_o[k]     = m_req_i;
            s_req_o[k].stb = m_req_i.stb & (sel == SLV_W'(k));   // Only one slave sees it
            s_req_o[k].cyc = m_req_i.cyc & (sel == SLV_W'(k));
        end
    end

    always_comb begin
        for (int k = 0; k < SLV_DEF; k++) begin
            rsp_all[k] = s_rsp_i[k];
        end
        // Unmapped space reads all ones and acks at once
        rsp_all[SLV_DEF].dat = '1;
        rsp_all[SLV_DEF].ack = s_req_o[SLV_DEF].stb & s_req_o[SLV_DEF].cyc;
    end

    assign m_rsp_o = rsp_all[sel];

endmodule

/* rtl/wb_ram.sv */
module wb_ram import tenyr_pkg::*; (
    input  logic    clk,
    input  wb_req_t req_i,
    output wb_rsp_t rsp_o
);

    logic [31:0] mem_q [2**RAM_ABITS];
    logic [31:0] dat_q;
    logic        ack_q;
    logic        access;

    // One access per strobe since the ack cycle is masked
    assign access = req_i.stb & req_i.cyc & ~ack_q;

    always_ff @(posedge clk) begin
        ack_q <= access;
        if (access) begin
            dat_q <= mem_q[req_i.adr.mem.idx];
            if (req_i.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (req_i.sel[b]) begin
                        mem_q[req_i.adr.mem.idx][8*b +: 8] <= req_i.dat[8*b +: 8];
                    end
                end
            end
        end
    end

    assign rsp_o.dat = dat_q;   // Old word on a write
    assign rsp_o.ack = ack_q;

endmodule

/* rtl/seg7_dev.sv */
module seg7_dev import tenyr_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  wb_req_t    req_i,
    output wb_rsp_t    rsp_o,
    output logic [7:0] seg_o,
    output logic [3:0] an_o
);

    logic [15:0]       value_q;
    logic [31:0]       dat_q;
    logic              ack_q;
    logic [SCAN_W-1:0] div_q;
    logic [1:0]        digit_q;
    logic              scan_on_q;
    logic              access;
    logic [3:0]        nibble;

    // Active-low gfedcba pattern
    function automatic logic [6:0] hex7(input logic [3:0] n);
        case (n)
            4'h0: hex7 = 7'h40;
            4'h1: hex7 = 7'h79;
            4'h2: hex7 = 7'h24;
            4'h3: hex7 = 7'h30;
            4'h4: hex7 = 7'h19;
            4'h5: hex7 = 7'h12;
            4'h6: hex7 = 7'h02;
            4'h7: hex7 = 7'h78;
            4'h8: hex7 = 7'h00;
            4'h9: hex7 = 7'h10;
            4'ha: hex7 = 7'h08;
            4'hb: hex7 = 7'h03;
            4'hc: hex7 = 7'h46;
            4'hd: hex7 = 7'h21;
            4'he: hex7 = 7'h06;
            default: hex7 = 7'h0e;
        endcase
    endfunction

    assign access = req_i.stb & req_i.cyc & ~ack_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            value_q <= '0;
            ack_q   <= 1'b0;
        end else begin
            ack_q <= access;
            if (access && req_i.we && req_i.adr.io.rnum == 2'd0) begin
                if (req_i.sel[0]) value_q[7:0]  <= req_i.dat[7:0];
                if (req_i.sel[1]) value_q[15:8] <= req_i.dat[15:8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            dat_q <= (req_i.adr.io.rnum == 2'd0) ? {16'h0, value_q} : 32'h0;
        end
    end

    // Digit moves every SCAN_DIV cycles and stays blank until the first wrap
    always_ff @(posedge clk) begin
        if (reset_i) begin
            div_q     <= '0;
            digit_q   <= '0;
            scan_on_q <= 1'b0;
        end else if (div_q == SCAN_W'(SCAN_DIV - 1)) begin
            div_q     <= '0;
            scan_on_q <= 1'b1;
            if (scan_on_q) digit_q <= digit_q + 1'b1;
        end else begin
            div_q <= div_q + 1'b1;
        end
    end

    assign nibble    = value_q[4*digit_q +: 4];
    assign an_o      = scan_on_q ? ~(4'b0001 << digit_q) : 4'hf;
    assign seg_o     = {1'b1, hex7(nibble)};   // Decimal point off
    assign rsp_o.dat = dat_q;
    assign rsp_o.ack = ack_q;

endmodule

/* rtl/gpio_dev.sv */
module gpio_dev import tenyr_pkg::*; (
    input  logic                  clk,
    input  logic                  reset_i,
    input  wb_req_t               req_i,
    output wb_rsp_t               rsp_o,
    input  logic [GPIO_COUNT-1:0] gpio_i,
    output logic [GPIO_COUNT-1:0] gpio_o,
    output logic [GPIO_COUNT-1:0] gpio_oe_o
);

    logic [GPIO_COUNT-1:0] data_q;
    logic [GPIO_COUNT-1:0] dir_q;    // 1 drives the pin
    logic [GPIO_COUNT-1:0] pins;
    logic                  access;

    assign access = req_i.stb & req_i.cyc;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            data_q <= '0;
            dir_q  <= '0;                          // All inputs
        end else if (access && req_i.we) begin
            case (req_i.adr.io.rnum)
                2'd0:    data_q <= req_i.dat[GPIO_COUNT-1:0];
                2'd1:    dir_q  <= req_i.dat[GPIO_COUNT-1:0];
                default: data_q <= data_q;
            endcase
        end
    end

    // Driven pins read back their own value
    assign pins = (data_q & dir_q) | (gpio_i & ~dir_q);

    always_comb begin
        rsp_o.ack = access;                        // Same-cycle ack
        case (req_i.adr.io.rnum)
            2'd0:    rsp_o.dat = 32'(pins);
            2'd1:    rsp_o.dat = 32'(dir_q);
            default: rsp_o.dat = 32'h0;
        endcase
    end

    assign gpio_o    = data_q;
    assign gpio_oe_o = dir_q;

endmodule

/* rtl/tenyr_soc.sv */
module tenyr_soc import tenyr_pkg::*; (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  cmd_valid_i,
    output logic                  cmd_ready_o,
    input  host_cmd_t             cmd_i,
    output logic                  rsp_valid_o,
    output host_rsp_t             rsp_o,
    output logic [7:0]            seg_o,
    output logic [3:0]            an_o,
    input  logic [GPIO_COUNT-1:0] gpio_i,
    output logic [GPIO_COUNT-1:0] gpio_o,
    output logic [GPIO_COUNT-1:0] gpio_oe_o
);

    logic      q_valid;
    logic      q_pop;
    host_cmd_t q_cmd;
    wb_req_t   m_req;
    wb_rsp_t   m_rsp;
    wb_req_t   s_req [NUM_SLAVES];
    wb_rsp_t   s_rsp [NUM_SLAVES];   // Default slave lives in the mux

    host_cmd_fifo i_host_cmd_fifo (
        .clk(clk), .reset_i(reset_i),
        .push_valid_i(cmd_valid_i), .push_ready_o(cmd_ready_o), .push_cmd_i(cmd_i),
        .pop_valid_o(q_valid), .pop_i(q_pop), .pop_cmd_o(q_cmd)
    );

    wb_host_master i_wb_host_master (
        .clk(clk), .reset_i(reset_i),
        .cmd_valid_i(q_valid), .cmd_pop_o(q_pop), .cmd_i(q_cmd),
        .wb_req_o(m_req), .wb_rsp_i(m_rsp),
        .rsp_valid_o(rsp_valid_o), .rsp_o(rsp_o)
    );

    wb_mux i_wb_mux (
        .clk(clk), .reset_i(reset_i),
        .m_req_i(m_req), .m_rsp_o(m_rsp),
        .s_req_o(s_req), .s_rsp_i(s_rsp)
    );

    wb_ram i_wb_ram (
        .clk(clk), .req_i(s_req[SLV_RAM]), .rsp_o(s_rsp[SLV_RAM])
    );

    seg7_dev i_seg7_dev (
        .clk(clk), .reset_i(reset_i),
        .req_i(s_req[SLV_SEG7]), .rsp_o(s_rsp[SLV_SEG7]),
        .seg_o(seg_o), .an_o(an_o)
    );

    gpio_dev i_gpio_dev (
        .clk(clk), .reset_i(reset_i),
        .req_i(s_req[SLV_GPIO]), .rsp_o(s_rsp[SLV_GPIO]),
        .gpio_i(gpio_i), .gpio_o(gpio_o), .gpio_oe_o(gpio_oe_o)
    );

endmodule

/* tb/tenyr_soc_assert.sv */
module tenyr_soc_assert import tenyr_pkg::*; (
    input logic    clk,
    input logic    reset_i,
    input wb_req_t m_req_i,
    input wb_rsp_t m_rsp_o,
    input wb_req_t s_req_o [NUM_SLAVES]
);

    logic [NUM_SLAVES-1:0] stb_vec;

    always_comb begin
        for (int k = 0; k < NUM_SLAVES; k++) begin
            stb_vec[k] = s_req_o[k].stb;
        end
    end

    a_stb_cyc: assert property (@(posedge clk) disable iff (reset_i)
        m_req_i.stb |-> m_req_i.cyc)
        else $error("master strobe high without cycle");

    // Master must hold the address until it sees the ack
    a_adr_stable: assert property (@(posedge clk) disable iff (reset_i)
        (m_req_i.stb && !m_rsp_o.ack) |=> $stable(m_req_i.adr))
        else $error("address changed before the acknowledge");

    a_one_slave: assert property (@(posedge clk) disable iff (reset_i)
        $onehot0(stb_vec))
        else $error("more than one slave strobe high");

endmodule

bind wb_mux tenyr_soc_assert i_tenyr_soc_assert (
    .clk(clk), .reset_i(reset_i), .m_req_i(m_req_i), .m_rsp_o(m_rsp_o), .s_req_o(s_req_o)
);

/* tb/tb_tenyr_soc.sv */
module tb_tenyr_soc import tenyr_pkg::*; ();

    localparam int unsigned           PERIOD  = 100;
    localparam logic [GPIO_COUNT-1:0] PINS_IN = 24'h3c96e1;   // Level seen on input pins

    logic                  clk;
    logic                  reset_i;
    logic                  cmd_valid_i;
    logic                  cmd_ready_o;
    host_cmd_t             cmd_i;
    logic                  rsp_valid_o;
    host_rsp_t             rsp_o;
    logic [7:0]            seg_o;
    logic [3:0]            an_o;
    logic [GPIO_COUNT-1:0] gpio_i;
    logic [GPIO_COUNT-1:0] gpio_o;
    logic [GPIO_COUNT-1:0] gpio_oe_o;

    string       tbl_name [$];
    host_cmd_t   tbl_cmd [$];
    logic [31:0] tbl_exp [$];
    bit          tbl_nowait [$];    // Next entry follows without draining

    // Commands in flight with the oldest first
    string       pend_name [$];
    logic [31:0] pend_exp [$];
    bit          pend_read [$];

    logic [31:0]           ram_sh [2**RAM_ABITS];
    logic [15:0]           seg_sh;
    logic [GPIO_COUNT-1:0] gdat_sh;
    logic [GPIO_COUNT-1:0] gdir_sh;

    int seed = 38264;
    int n_pass;
    int n_fail;
    bit saw_full;

    tenyr_soc i_tenyr_soc (
        .clk(clk), .reset_i(reset_i),
        .cmd_valid_i(cmd_valid_i), .cmd_ready_o(cmd_ready_o), .cmd_i(cmd_i),
        .rsp_valid_o(rsp_valid_o), .rsp_o(rsp_o),
        .seg_o(seg_o), .an_o(an_o),
        .gpio_i(gpio_i), .gpio_o(gpio_o), .gpio_oe_o(gpio_oe_o)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Active-low segments with the dp in bit 7 kept dark
    function automatic logic [7:0] seg_pattern(input logic [3:0] n);
        case (n)
            4'h0: seg_pattern = 8'hc0;
            4'h1: seg_pattern = 8'hf9;
            4'h2: seg_pattern = 8'ha4;
            4'h3: seg_pattern = 8'hb0;
            4'h4: seg_pattern = 8'h99;
            4'h5: seg_pattern = 8'h92;
            4'h6: seg_pattern = 8'h82;
            4'h7: seg_pattern = 8'hf8;
            4'h8: seg_pattern = 8'h80;
            4'h9: seg_pattern = 8'h90;
            4'ha: seg_pattern = 8'h88;
            4'hb: seg_pattern = 8'h83;
            4'hc: seg_pattern = 8'hc6;
            4'hd: seg_pattern = 8'ha1;
            4'he: seg_pattern = 8'h86;
            default: seg_pattern = 8'h8e;
        endcase
    endfunction

    // Returns the read value and updates the shadows for a write
    function automatic logic [31:0] model_access(input host_cmd_t c);
        logic [31:0]          a;
        logic [31:0]          rd;
        logic [RAM_ABITS-1:0] idx;
        a   = c.adr;
        idx = a[RAM_ABITS-1:0];
        rd  = 32'hffff_ffff;                                 // Unmapped space
        if (a >= GPIO_BASE && a < GPIO_BASE + 32'd4) begin
            case (a[1:0])
                2'd0: begin
                    rd = 32'h0;
                    for (int p = 0; p < int'(GPIO_COUNT); p++) begin
                        rd[p] = gdir_sh[p] ? gdat_sh[p] : PINS_IN[p];   // Output pins echo data
                    end
                end
                2'd1:    rd = 32'(gdir_sh);
                default: rd = 32'h0;
            endcase
            if (c.we && a[1:0] == 2'd0) gdat_sh = c.dat[GPIO_COUNT-1:0];
            if (c.we && a[1:0] == 2'd1) gdir_sh = c.dat[GPIO_COUNT-1:0];
        end else if (a >= SEG7_BASE && a < SEG7_BASE + 32'd2) begin
            rd = a[0] ? 32'h0 : {16'h0, seg_sh};
            if (c.we && !a[0] && c.sel[0]) seg_sh[7:0] = c.dat[7:0];
            if (c.we && !a[0] && c.sel[1]) seg_sh[15:8] = c.dat[15:8];
        end else if (a >= RAM_BASE && a < RAM_BASE + 32'(2**RAM_ABITS)) begin
            rd = ram_sh[idx];
            if (c.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (c.sel[b]) ram_sh[idx][8*b +: 8] = c.dat[8*b +: 8];
                end
            end
        end
        return rd;
    endfunction

    task automatic add_entry(input string name, input logic we, input logic [3:0] sel,
                             input logic [31:0] adr, input logic [31:0] dat, input bit nowait);
        host_cmd_t c;
        c.we  = we;
        c.sel = sel;
        c.adr = adr;
        c.dat = dat;
        tbl_name.push_back(name);
        tbl_cmd.push_back(c);
        tbl_exp.push_back(model_access(c));
        tbl_nowait.push_back(nowait);
    endtask

    task automatic build_table();
        logic [31:0] wd;
        for (int i = 0; i < 4; i++) begin
            wd = $random(seed);
            add_entry($sformatf("ram write %0d", i), 1'b1, 4'hf,
                      RAM_BASE + 32'(i * 37 + 5), wd, 1'b0);
        end
        for (int i = 0; i < 4; i++) begin
            add_entry($sformatf("ram read %0d", i), 1'b0, 4'hf,
                      RAM_BASE + 32'(i * 37 + 5), 32'h0, 1'b0);
        end
        add_entry("byte base write", 1'b1, 4'hf, RAM_BASE + 32'h80, 32'h1122_3344, 1'b0);
        add_entry("byte sel 0101 write", 1'b1, 4'b0101, RAM_BASE + 32'h80, 32'haabb_ccdd, 1'b0);
        add_entry("byte sel 1000 write", 1'b1, 4'b1000, RAM_BASE + 32'h80, 32'h99ee_ff00, 1'b0);
        add_entry("byte sel read", 1'b0, 4'hf, RAM_BASE + 32'h80, 32'h0, 1'b0);
        add_entry("unmapped read", 1'b0, 4'hf, 32'h0000_3000, 32'h0, 1'b0);
        add_entry("ram mask bit 8 read", 1'b0, 4'hf, RAM_BASE | 32'h100, 32'h0, 1'b0);
        add_entry("ram mask bit 16 read", 1'b0, 4'hf, 32'h0001_1005, 32'h0, 1'b0);
        add_entry("seg7 gap read", 1'b0, 4'hf, SEG7_BASE + 32'd2, 32'h0, 1'b0);
        add_entry("gpio dir write", 1'b1, 4'hf, GPIO_BASE + 32'd1, 32'h0000_ff0f, 1'b0);
        add_entry("gpio data write", 1'b1, 4'hf, GPIO_BASE, 32'hffa5_a5a5, 1'b0);
        add_entry("gpio dir read", 1'b0, 4'hf, GPIO_BASE + 32'd1, 32'h0, 1'b0);
        add_entry("gpio pin read", 1'b0, 4'hf, GPIO_BASE, 32'h0, 1'b0);
        add_entry("seg7 write a", 1'b1, 4'hf, SEG7_BASE, 32'h0000_1234, 1'b0);
        add_entry("seg7 read a", 1'b0, 4'hf, SEG7_BASE, 32'h0, 1'b0);
        add_entry("seg7 write b", 1'b1, 4'hf, SEG7_BASE, 32'hdead_c5a9, 1'b0);
        add_entry("seg7 read b", 1'b0, 4'hf, SEG7_BASE, 32'h0, 1'b0);
        for (int i = 0; i < 3; i++) begin
            wd = $random(seed);
            add_entry($sformatf("burst write %0d", i), 1'b1, 4'hf,
                      RAM_BASE + 32'h40 + 32'(i), wd, 1'b1);
        end
        for (int i = 0; i < 3; i++) begin
            add_entry($sformatf("burst read %0d", i), 1'b0, 4'hf,
                      RAM_BASE + 32'h40 + 32'(i), 32'h0, i != 2);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        bit ok;
        ok = (act === exp);
        assert (ok) else begin
            n_fail++;
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
        end
        if (ok) begin
            n_pass++;
            $display("[PASS] %s", name);
        end
    endtask

    task automatic check_cond(input string name, input bit cond, input string what);
        assert (cond) else begin
            n_fail++;
            $display("[ERROR] %s: %s", name, what);
        end
        if (cond) begin
            n_pass++;
            $display("[PASS] %s", name);
        end
    endtask

    // Starts on a falling edge and returns one falling edge after acceptance
    task automatic send_cmd(input int i);
        cmd_valid_i = 1'b1;
        cmd_i       = tbl_cmd[i];
        while (!cmd_ready_o) begin
            saw_full = 1'b1;                                 // Queue full so the command waits
            @(negedge clk);
        end
        pend_name.push_back(tbl_name[i]);
        pend_exp.push_back(tbl_exp[i]);
        pend_read.push_back(!tbl_cmd[i].we);
        @(negedge clk);
        cmd_valid_i = 1'b0;
    endtask

    task automatic drain();
        while (pend_exp.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic check_scan();
        logic [3:0] seen;
        logic [7:0] exp_seg;
        int         dig;
        bit         bad;
        seen = '0;
        bad  = 1'b0;
        for (int n = 0; n < int'(4 * SCAN_DIV); n++) begin
            @(negedge clk);
            dig = 0;
            for (int k = 0; k < 4; k++) begin
                if (!an_o[k]) dig = k;
            end
            assert ($countones(~an_o) == 1) else begin
                $display("[ERROR] seg7 scan: an_o %b does not select exactly one digit", an_o);
                bad = 1'b1;
            end
            if (bad) break;
            exp_seg   = seg_pattern(seg_sh[4*dig +: 4]);
            seen[dig] = 1'b1;
            assert (seg_o == exp_seg) else begin
                $display("[ERROR] seg7 scan digit %0d expected %h actual %h",
                         dig, exp_seg, seg_o);
                bad = 1'b1;
            end
            if (bad) break;
        end
        if (!bad) begin
            assert (seen == 4'hf) else begin
                $display("[ERROR] seg7 scan: not every digit was selected during the scan");
                bad = 1'b1;
            end
        end
        if (bad) begin
            n_fail++;
        end else begin
            n_pass++;
            $display("[PASS] seg7 scan");
        end
    endtask

    // Response pulses are one cycle wide and stable at the falling edge
    always @(negedge clk) begin
        if (!reset_i && rsp_valid_o) begin
            assert (pend_exp.size() != 0) else begin
                n_fail++;
                $display("[ERROR] a response arrived with no command outstanding");
            end
            if (pend_exp.size() != 0) begin
                if (pend_read[0]) begin
                    check_value(pend_name[0], pend_exp[0], rsp_o.dat);
                end else begin
                    n_pass++;
                    $display("[PASS] %s", pend_name[0]);
                end
                void'(pend_name.pop_front());
                void'(pend_exp.pop_front());
                void'(pend_read.pop_front());
            end
        end
    end

    initial begin
        longint limit;
        #1;
        limit = longint'(tbl_cmd.size() * 50 + 4 * SCAN_DIV + 20) * PERIOD;
        #(limit);
        $display("[ERROR] watchdog expired after %0d time units, the run did not finish", limit);
        $display("test failed");
        $finish;
    end

    initial begin
        cmd_valid_i = 1'b0;
        cmd_i       = '0;
        gpio_i      = PINS_IN;
        reset_i     = 1'b1;
        n_pass      = 0;
        n_fail      = 0;
        saw_full    = 1'b0;
        seg_sh      = '0;
        gdat_sh     = '0;
        gdir_sh     = '0;                                    // All pins start as inputs
        build_table();
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        check_value("reset state", {2'b0, 1'b1, 1'b0, 4'hf, 24'h0},
                    {2'b0, cmd_ready_o, rsp_valid_o, an_o, gpio_oe_o});
        for (int i = 0; i < tbl_cmd.size(); i++) begin
            send_cmd(i);
            if (!tbl_nowait[i]) drain();
        end
        check_cond("queue back-pressure", saw_full,
                   "cmd_ready_o never went low while the burst filled the queue");
        check_value("gpio_o pins", 32'(gdat_sh), 32'(gpio_o));
        check_value("gpio_oe_o pins", 32'(gdir_sh), 32'(gpio_oe_o));
        check_scan();
        $display("%0d tests, %0d passed, %0d failed", n_pass + n_fail, n_pass, n_fail);
        if (n_fail == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* list.f */
rtl/tenyr_pkg.sv
rtl/host_cmd_fifo.sv
rtl/wb_host_master.sv
rtl/wb_mux.sv
rtl/wb_ram.sv
rtl/seg7_dev.sv
rtl/gpio_dev.sv
rtl/tenyr_soc.sv
tb/tenyr_soc_assert.sv
tb/tb_tenyr_soc.sv

/* run.sh */
#!/bin/sh
# Build and run the tenyr_soc testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_tenyr_soc -f list.f -o sim_tenyr_soc
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tenyr_soc > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" "$LOG"; then
    exit 0
fi
exit 1
